//--- filelist.f
rtl/demux_cfg_pkg.sv
rtl/demux_bus_pkg.sv
rtl/id_slot.sv
rtl/id_tracker.sv
rtl/req_demux.sv
rtl/rsp_merge.sv
rtl/demux_top.sv
sim/tb_target_model.sv
sim/tb_demux_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary -j 0 --assert --top-module tb_demux_top -f filelist.f -o vtb
	out="$$(obj_dir/vtb)"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- sim/tb_demux_top.sv
// ----------------------------------------------------------
// testbench for demux_top: four target models, scoreboard,
// routing / order / capacity / busy checks, watchdog
// ----------------------------------------------------------
`default_nettype none

module tb_demux_top import demux_cfg_pkg::*, demux_bus_pkg::*;;

  localparam int          NUM_RAND  = 60;
  localparam int          NUM_CAP   = 10;
  localparam int          MAX_LAT   = 8;
  localparam logic [31:0] RDATA_KEY = 32'ha5c3_3c5a;
  // requests times worst latency times 4
  localparam int          WDOG_CYC  = (NUM_RAND + NUM_CAP) * MAX_LAT * 4;
  localparam int          ID_LIMIT  = 7;

  logic clk_i;
  logic rst_i;
  logic req_valid_i;
  bus_req_t req_i;
  logic req_ready_o;
  logic [NUM_TARGETS-1:0] tgt_req_valid;
  bus_req_t [NUM_TARGETS-1:0] tgt_req;
  logic [NUM_TARGETS-1:0] tgt_req_ready;
  logic [NUM_TARGETS-1:0] tgt_rsp_valid;
  bus_rsp_t [NUM_TARGETS-1:0] tgt_rsp;
  logic [NUM_TARGETS-1:0] tgt_rsp_ready;
  logic rsp_valid_o;
  bus_rsp_t rsp_o;
  logic busy_o;
  logic [NUM_TARGETS-1:0] hold;

  // scoreboard state
  int          seed;
  int          errors;
  int          checks;
  int          tests;
  int          open_cnt[NUM_IDS];
  tgt_sel_t    open_tgt[NUM_IDS];
  logic [31:0] exp_q[NUM_IDS][$];
  bus_req_t    fwd_q[NUM_TARGETS][$];

  demux_top dut0 (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .tgt_req_valid_o (tgt_req_valid),
    .tgt_req_o       (tgt_req),
    .tgt_req_ready_i (tgt_req_ready),
    .tgt_rsp_valid_i (tgt_rsp_valid),
    .tgt_rsp_i       (tgt_rsp),
    .tgt_rsp_ready_o (tgt_rsp_ready),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o),
    .busy_o          (busy_o)
  );

  for (genvar t = 0; t < NUM_TARGETS; t++) begin : gen_tgt
    tb_target_model #(.SEED(55478 + t + 1), .MAX_LAT(MAX_LAT), .RDATA_KEY(RDATA_KEY)) u_tgt (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .hold_i      (hold[t]),
      .req_valid_i (tgt_req_valid[t]),
      .req_i       (tgt_req[t]),
      .req_ready_o (tgt_req_ready[t]),
      .rsp_valid_o (tgt_rsp_valid[t]),
      .rsp_o       (tgt_rsp[t]),
      .rsp_ready_i (tgt_rsp_ready[t])
    );
  end

  always #50 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  task automatic check(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("[ERROR] %0t %s", $time, msg);
      errors++;
    end
  endtask

  function automatic logic any_open();
    logic r;
    r = 1'b0;
    for (int i = 0; i < NUM_IDS; i++) begin
      r = r | (open_cnt[i] != 0);
    end
    return r;
  endfunction

  function automatic logic queues_empty();
    logic r;
    r = 1'b1;
    for (int i = 0; i < NUM_IDS; i++) begin
      r = r & (exp_q[i].size() == 0);
    end
    return r;
  endfunction

  // drive one request and hold it until taken
  task automatic send_req(input id_t id, input tgt_sel_t tgt);
    logic taken;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i.id    = id;
    req_i.we    = 1'b0;
    req_i.addr  = {tgt, 14'($random(seed))};
    req_i.wdata = $random(seed);
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk_i);
      taken = req_ready_o;
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // every expected response has come back
  task automatic wait_drain();
    @(negedge clk_i);
    while (!queues_empty()) begin
      @(negedge clk_i);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %-14s %s", name, (errors == err_before) ? "ok" : "errors");
  endtask

  // ----------------------------------------------------------
  // monitor at the rising edge, handshakes and scoreboard
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    tgt_sel_t sel;
    id_t      rid;
    if (!rst_i) begin
      // routing and payload
      for (int t = 0; t < NUM_TARGETS; t++) begin
        if (tgt_req_valid[t] && tgt_req_ready[t]) begin
          check(fwd_q[t].size() > 0, "request forwarded to unexpected target");
          if (fwd_q[t].size() > 0) begin
            check(tgt_req[t] == fwd_q[t].pop_front(), "forwarded payload mismatch");
          end
        end
        if (tgt_rsp_valid[t] && tgt_rsp_ready[t]) begin
          open_cnt[tgt_rsp[t].id]--;
        end
      end
      // upstream response order and data
      if (rsp_valid_o) begin
        rid = rsp_o.id;
        check(!rsp_o.err, "response error flag set");
        check(exp_q[rid].size() > 0, "response for an id with nothing open");
        if (exp_q[rid].size() > 0) begin
          check(rsp_o.rdata == exp_q[rid].pop_front(), "response data or order wrong");
        end
      end
      // ordering and capacity rules on the waiting request
      if (req_valid_i) begin
        sel = req_i.addr[ADDR_WIDTH-1 -: TGT_BITS];
        if (open_cnt[req_i.id] >= ID_LIMIT ||
            (open_cnt[req_i.id] != 0 && open_tgt[req_i.id] != sel)) begin
          check(!req_ready_o, "request accepted against ordering or capacity rule");
        end
        if (req_ready_o) begin
          open_cnt[req_i.id]++;
          open_tgt[req_i.id] = sel;
          exp_q[req_i.id].push_back({16'h0, req_i.addr} ^ RDATA_KEY);
          fwd_q[sel].push_back(req_i);
        end
      end
    end
  end

  // busy must follow the open counts
  always @(negedge clk_i) begin
    if (!rst_i) begin
      check(busy_o == any_open(), "busy_o disagrees with open count");
    end
  end

  // watchdog
  initial begin
    repeat (WDOG_CYC) @(posedge clk_i);
    $display("watchdog expired, a request or response never completed");
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    int e0;
    seed        = 55478;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    hold        = '0;
    for (int i = 0; i < NUM_IDS; i++) begin
      open_cnt[i] = 0;
      open_tgt[i] = '0;
    end
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;

    // reset state
    e0 = errors;
    @(negedge clk_i);
    check(req_ready_o, "req_ready_o low after reset");
    check(tgt_req_valid == '0 && tgt_rsp_ready == '0, "target valid or ready high after reset");
    check(!rsp_valid_o && !busy_o, "rsp_valid_o or busy_o high after reset");
    report_test("reset_state", e0);

    // random ids and targets, conflicts included
    e0 = errors;
    for (int n = 0; n < NUM_RAND; n++) begin
      send_req(id_t'($random(seed)), tgt_sel_t'($random(seed)));
    end
    wait_drain();
    report_test("random_traffic", e0);

    // id 0 fills up behind a withheld target 0
    e0 = errors;
    hold[0] = 1'b1;
    for (int n = 0; n < ID_LIMIT; n++) begin
      send_req(id_t'(0), tgt_sel_t'(0));
    end
    send_req(id_t'(1), tgt_sel_t'(1));
    send_req(id_t'(2), tgt_sel_t'(2));
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i.id    = id_t'(0);
    req_i.addr  = {2'd0, 14'($random(seed))};
    repeat (10) begin
      @(posedge clk_i);
      check(!req_ready_o, "full id not stalled");
    end
    @(negedge clk_i);
    hold[0] = 1'b0;
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    wait_drain();
    report_test("capacity", e0);

    // everything returned
    e0 = errors;
    repeat (3) @(negedge clk_i);
    check(!busy_o, "busy_o high after all responses returned");
    report_test("drain_status", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tb_target_model.sv
// ----------------------------------------------------------
// in-order target model: random request ready, random
// response latency, read data is the address xor a key
// ----------------------------------------------------------
`default_nettype none

module tb_target_model import demux_cfg_pkg::*, demux_bus_pkg::*; #(
  parameter int              SEED      = 1,
  parameter int              MAX_LAT   = 8,
  parameter logic [31:0]     RDATA_KEY = 32'h0
) (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  // withholds responses while high
  input  wire logic     hold_i,
  input  wire logic     req_valid_i,
  input  wire bus_req_t req_i,
  output logic          req_ready_o,
  output logic          rsp_valid_o,
  output bus_rsp_t      rsp_o,
  input  wire logic     rsp_ready_i
);

  bus_req_t pend_q[$];
  int       due_q[$];
  int       cycle;
  int       seed;

  initial begin
    seed        = SEED;
    cycle       = 0;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
  end

  // handshakes seen at the rising edge
  always @(posedge clk_i) begin
    if (rst_i) begin
      pend_q.delete();
      due_q.delete();
      cycle = 0;
    end else begin
      cycle = cycle + 1;
      if (rsp_valid_o && rsp_ready_i) begin
        void'(pend_q.pop_front());
        void'(due_q.pop_front());
      end
      if (req_valid_i && req_ready_o) begin
        pend_q.push_back(req_i);
        due_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % MAX_LAT));
      end
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk_i) begin
    req_ready_o = !rst_i && (($random(seed) & 3) != 0);
    rsp_valid_o = !rst_i && !hold_i && (pend_q.size() > 0) && (due_q[0] <= cycle);
    if (pend_q.size() > 0) begin
      rsp_o.id    = pend_q[0].id;
      rsp_o.rdata = {16'h0, pend_q[0].addr} ^ RDATA_KEY;
      rsp_o.err   = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/demux_top.sv
// ----------------------------------------------------------
// request demux top: routing, id tracking, response merge
// ----------------------------------------------------------
`default_nettype none

module demux_top import demux_cfg_pkg::*, demux_bus_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // upstream request
  input  logic                       req_valid_i,
  input  bus_req_t                   req_i,
  output logic                       req_ready_o,
  // target requests
  output logic     [NUM_TARGETS-1:0] tgt_req_valid_o,
  output bus_req_t [NUM_TARGETS-1:0] tgt_req_o,
  input  logic     [NUM_TARGETS-1:0] tgt_req_ready_i,
  // target responses
  input  logic     [NUM_TARGETS-1:0] tgt_rsp_valid_i,
  input  bus_rsp_t [NUM_TARGETS-1:0] tgt_rsp_i,
  output logic     [NUM_TARGETS-1:0] tgt_rsp_ready_o,
  // upstream response strobe
  output logic                       rsp_valid_o,
  output bus_rsp_t                   rsp_o,
  // transactions in flight
  output logic                       busy_o
);

  // ----------------------------------------------------------
  // tracker wires
  // ----------------------------------------------------------
  id_t      lookup_id;
  tgt_sel_t lookup_tgt;
  logic     lookup_occupied;
  logic     lookup_full;
  logic     push;
  id_t      push_id;
  tgt_sel_t push_tgt;
  logic     pop;
  id_t      pop_id;

  req_demux u_req_demux (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .req_valid_i       (req_valid_i),
    .req_i             (req_i),
    .req_ready_o       (req_ready_o),
    .tgt_req_valid_o   (tgt_req_valid_o),
    .tgt_req_o         (tgt_req_o),
    .tgt_req_ready_i   (tgt_req_ready_i),
    .lookup_id_o       (lookup_id),
    .lookup_tgt_i      (lookup_tgt),
    .lookup_occupied_i (lookup_occupied),
    .lookup_full_i     (lookup_full),
    .push_o            (push),
    .push_id_o         (push_id),
    .push_tgt_o        (push_tgt)
  );

  id_tracker u_id_tracker (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .push_i            (push),
    .push_id_i         (push_id),
    .push_tgt_i        (push_tgt),
    .pop_i             (pop),
    .pop_id_i          (pop_id),
    .lookup_id_i       (lookup_id),
    .lookup_tgt_o      (lookup_tgt),
    .lookup_occupied_o (lookup_occupied),
    .lookup_full_o     (lookup_full),
    .busy_o            (busy_o)
  );

  rsp_merge u_rsp_merge (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .tgt_rsp_valid_i (tgt_rsp_valid_i),
    .tgt_rsp_i       (tgt_rsp_i),
    .tgt_rsp_ready_o (tgt_rsp_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o),
    .pop_o           (pop),
    .pop_id_o        (pop_id)
  );

endmodule

`default_nettype wire

//--- rtl/rsp_merge.sv
// ----------------------------------------------------------
// round-robin merge of target responses onto the upstream
// strobe, with tracker pop on every grant
// ----------------------------------------------------------
`default_nettype none

module rsp_merge import demux_cfg_pkg::*, demux_bus_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // target responses
  input  logic     [NUM_TARGETS-1:0] tgt_rsp_valid_i,
  input  bus_rsp_t [NUM_TARGETS-1:0] tgt_rsp_i,
  output logic     [NUM_TARGETS-1:0] tgt_rsp_ready_o,
  // upstream strobe, no back-pressure
  output logic                       rsp_valid_o,
  output bus_rsp_t                   rsp_o,
  // tracker pop
  output logic                       pop_o,
  output id_t                        pop_id_o
);

  // first target looked at this cycle
  tgt_sel_t                 ptr_q;
  logic [NUM_TARGETS-1:0]   grant;
  tgt_sel_t                 gnt_idx;
  logic                     gnt_any;
  logic                     rsp_valid_q;
  bus_rsp_t                 rsp_q;

  // ----------------------------------------------------------
  // arbiter
  // ----------------------------------------------------------
  always_comb begin : arb
    tgt_sel_t idx;
    logic     found;
    grant   = '0;
    gnt_idx = ptr_q;
    found   = 1'b0;
    // scan from the pointer, wraps through the index width
    for (int i = 0; i < NUM_TARGETS; i++) begin
      idx = ptr_q + tgt_sel_t'(i);
      if (!found && tgt_rsp_valid_i[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        gnt_idx    = idx;
      end
    end
  end

  assign gnt_any = |grant;
  // only the winner is told ready
  assign tgt_rsp_ready_o = grant;

  // pop at the taking edge
  assign pop_o    = gnt_any;
  assign pop_id_o = tgt_rsp_i[gnt_idx].id;

  // pointer moves past the winner
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q       <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= gnt_any;
      if (gnt_any) begin
        ptr_q <= gnt_idx + tgt_sel_t'(1);
      end
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (gnt_any) begin
      rsp_q <= tgt_rsp_i[gnt_idx];
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  // at most one target taken per cycle
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(grant));

endmodule

`default_nettype wire

//--- rtl/req_demux.sv
// ----------------------------------------------------------
// request routing: address decode, per-id ordering stall
// and one output register per target
// ----------------------------------------------------------
`default_nettype none

module req_demux import demux_cfg_pkg::*, demux_bus_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // upstream request
  input  logic                         req_valid_i,
  input  bus_req_t                     req_i,
  output logic                         req_ready_o,
  // target requests
  output logic     [NUM_TARGETS-1:0]   tgt_req_valid_o,
  output bus_req_t [NUM_TARGETS-1:0]   tgt_req_o,
  input  logic     [NUM_TARGETS-1:0]   tgt_req_ready_i,
  // tracker lookup
  output id_t                          lookup_id_o,
  input  tgt_sel_t                     lookup_tgt_i,
  input  logic                         lookup_occupied_i,
  input  logic                         lookup_full_i,
  // tracker push
  output logic                         push_o,
  output id_t                          push_id_o,
  output tgt_sel_t                     push_tgt_o
);

  // decoded target of the waiting request
  tgt_sel_t sel;
  // ordering and capacity ok for this id
  logic     id_ok;
  // output register free or emptying at this edge
  logic [NUM_TARGETS-1:0] slot_free;
  // register write enables
  logic [NUM_TARGETS-1:0] load;
  logic                   accept;

  // output registers
  logic     [NUM_TARGETS-1:0] valid_q;
  bus_req_t [NUM_TARGETS-1:0] data_q;

  // ----------------------------------------------------------
  // decode and accept
  // ----------------------------------------------------------
  // top address bits select the target, no holes in the map
  assign sel = tgt_sel_t'(req_i.addr[ADDR_WIDTH-1 -: TGT_BITS]);

  assign lookup_id_o = req_i.id;

  // id must be free or already open at the same target,
  // otherwise responses could overtake each other
  assign id_ok = !lookup_full_i && (!lookup_occupied_i || (lookup_tgt_i == sel));

  assign slot_free = ~valid_q | tgt_req_ready_i;

  // only the chosen target's register matters,
  // a stalled target does not block the others
  assign req_ready_o = slot_free[sel] && id_ok;
  assign accept      = req_valid_i && req_ready_o;

  // tracker push at the accepting edge
  assign push_o     = accept;
  assign push_id_o  = req_i.id;
  assign push_tgt_o = sel;

  // ----------------------------------------------------------
  // per-target output registers
  // ----------------------------------------------------------
  for (genvar t = 0; t < NUM_TARGETS; t++) begin : gen_tgt
    assign load[t] = accept && (sel == tgt_sel_t'(t));

    // valid set on load, cleared on drain
    // load wins when both happen at one edge
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        valid_q[t] <= 1'b0;
      end else if (load[t]) begin
        valid_q[t] <= 1'b1;
      end else if (tgt_req_ready_i[t]) begin
        valid_q[t] <= 1'b0;
      end
    end

    // payload, no reset
    always_ff @(posedge clk_i) begin
      if (load[t]) begin
        data_q[t] <= req_i;
      end
    end

    // a held request stays put until the target takes it
    a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      valid_q[t] && !tgt_req_ready_i[t] |=> valid_q[t] && $stable(data_q[t]));
  end

  assign tgt_req_valid_o = valid_q;
  assign tgt_req_o       = data_q;

endmodule

`default_nettype wire

//--- rtl/id_tracker.sv
// ----------------------------------------------------------
// per-id tracking slots with lookup, push, pop and busy flag
// ----------------------------------------------------------
`default_nettype none

module id_tracker import demux_cfg_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // push from the request side
  input  logic     push_i,
  input  id_t      push_id_i,
  input  tgt_sel_t push_tgt_i,
  // pop from the response side
  input  logic     pop_i,
  input  id_t      pop_id_i,
  // lookup for the waiting request
  input  id_t      lookup_id_i,
  output tgt_sel_t lookup_tgt_o,
  output logic     lookup_occupied_o,
  output logic     lookup_full_o,
  // anything still in flight
  output logic     busy_o
);

  // one-hot slot enables
  logic [NUM_IDS-1:0] push_en;
  logic [NUM_IDS-1:0] pop_en;

  // per-slot status
  tgt_sel_t [NUM_IDS-1:0] slot_tgt;
  logic     [NUM_IDS-1:0] slot_occupied;
  logic     [NUM_IDS-1:0] slot_full;

  assign push_en = push_i ? (NUM_IDS'(1) << push_id_i) : '0;
  assign pop_en  = pop_i ? (NUM_IDS'(1) << pop_id_i) : '0;

  // ----------------------------------------------------------
  // slots
  // ----------------------------------------------------------
  for (genvar i = 0; i < NUM_IDS; i++) begin : gen_slot
    id_slot u_slot (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .push_i     (push_en[i]),
      .push_tgt_i (push_tgt_i),
      .pop_i      (pop_en[i]),
      .tgt_o      (slot_tgt[i]),
      .occupied_o (slot_occupied[i]),
      .full_o     (slot_full[i])
    );
  end

  // lookup mux
  assign lookup_tgt_o      = slot_tgt[lookup_id_i];
  assign lookup_occupied_o = slot_occupied[lookup_id_i];
  assign lookup_full_o     = slot_full[lookup_id_i];

  assign busy_o = |slot_occupied;

endmodule

`default_nettype wire

//--- rtl/id_slot.sv
// ----------------------------------------------------------
// in-flight counter and stored target for one id
// ----------------------------------------------------------
`default_nettype none

module id_slot import demux_cfg_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // request side, one more in flight
  input  logic     push_i,
  input  tgt_sel_t push_tgt_i,
  // response side, one less in flight
  input  logic     pop_i,
  // status
  output tgt_sel_t tgt_o,
  output logic     occupied_o,
  output logic     full_o
);

  logic [CNT_WIDTH-1:0] cnt_q;
  tgt_sel_t             tgt_q;

  // push and pop together cancel out
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      unique case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + CNT_WIDTH'(1);
        2'b01:   cnt_q <= cnt_q - CNT_WIDTH'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // target of the open transactions
  // only meaningful while occupied
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      tgt_q <= push_tgt_i;
    end
  end

  assign tgt_o      = tgt_q;
  assign occupied_o = |cnt_q;
  // all ones is the limit
  assign full_o     = &cnt_q;

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // a response for an id with nothing open means a target misbehaved
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> occupied_o);

  // the request side must stall on a full id
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full_o);

endmodule

`default_nettype wire

//--- rtl/demux_bus_pkg.sv
// ----------------------------------------------------------
// request and response payloads of the split-transaction bus
// ----------------------------------------------------------
`default_nettype none

package demux_bus_pkg;

  import demux_cfg_pkg::*;

  // ----------------------------------------------------------
  // request, 51 bits
  // ----------------------------------------------------------
  typedef struct packed {
    // transaction id, sets the response order
    id_t                   id;
    // 1 for write, 0 for read
    logic                  we;
    // top TGT_BITS bits pick the target
    logic [ADDR_WIDTH-1:0] addr;
    // ignored on reads
    logic [DATA_WIDTH-1:0] wdata;
  } bus_req_t;

  // ----------------------------------------------------------
  // response, 35 bits
  // ----------------------------------------------------------
  typedef struct packed {
    // id copied from the request
    id_t                   id;
    // read data, don't care on writes
    logic [DATA_WIDTH-1:0] rdata;
    // target reported an error
    logic                  err;
  } bus_rsp_t;

endpackage

`default_nettype wire

//--- rtl/demux_cfg_pkg.sv
// ----------------------------------------------------------
// sizes of the request demux and the small index types
// shared by every RTL block
// ----------------------------------------------------------
`default_nettype none

package demux_cfg_pkg;

  // target side
  localparam int unsigned NUM_TARGETS = 4;
  localparam int unsigned TGT_BITS    = 2;

  // id tracking, one slot per id value
  localparam int unsigned ID_BITS     = 2;
  localparam int unsigned NUM_IDS     = 2 ** ID_BITS;
  // in-flight counter, saturates at 7 per id
  localparam int unsigned CNT_WIDTH   = 3;

  // bus payload widths
  localparam int unsigned ADDR_WIDTH  = 16;
  localparam int unsigned DATA_WIDTH  = 32;

  // index of a target port
  typedef logic [TGT_BITS-1:0] tgt_sel_t;

  // transaction id
  typedef logic [ID_BITS-1:0] id_t;

endpackage

`default_nettype wire
